// ==== filelist.f ====
logic/pipe_pkg.sv
logic/hazard_unit.sv
logic/fetch_unit.sv
logic/inst_fifo.sv
logic/backend_pipe.sv
logic/pipe_top.sv
tb/tb_clock.sv
tb/pipe_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module pipe_tb -o pipe_sim

output=$(./obj_dir/pipe_sim)
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi

// ==== tb/pipe_tb.sv ====
module pipe_tb;
    import pipe_pkg::*;

    localparam int clk_period      = 40;
    localparam int depth           = 4;
    localparam int n_rows          = 13;
    localparam int min_gap         = 14;
    localparam int max_gap         = 21;
    localparam int drain_cycles    = depth + 12;
    localparam int watchdog_cycles = 8 + n_rows * (max_gap + 3) + drain_cycles;

    logic              clk;
    logic              reset;
    logic              flush_from_wb;
    logic              flush_from_ex2;
    logic              flush_from_ex1;
    logic              flush_from_reg;
    logic              flush_from_id;
    logic              flush_from_fifo;
    logic              flush_from_if1;
    logic [addr_w-1:0] redirect_pc_wb;
    logic [addr_w-1:0] redirect_pc_ex2;
    logic [addr_w-1:0] redirect_pc_ex1;
    logic [addr_w-1:0] redirect_pc_reg;
    logic [addr_w-1:0] redirect_pc_id;
    logic [addr_w-1:0] redirect_pc_fifo;
    logic [addr_w-1:0] redirect_pc_if1;
    logic              wb_valid;
    logic [addr_w-1:0] wb_pc;
    logic              flush_to_tlb;
    logic              flush_to_icache;
    logic              flush_to_dcache;
    logic              flush_to_btb;

    // bit order follows the package source index, wb in bit 0.
    logic [n_flush_src-1:0] row_src [n_rows];
    logic [addr_w-1:0]      row_base [n_rows];
    logic [addr_w-1:0]      row_win [n_rows];
    // {tlb, icache, dcache, btb}.
    logic [3:0]             row_levels [n_rows];

    int                errors;
    int                retires;
    int                pending_age;
    int                gap;
    logic              have_prev;
    logic              pending_valid;
    logic [addr_w-1:0] prev_pc;
    logic [addr_w-1:0] pending_pc;

    tb_clock #(
        .period (clk_period)
    ) u_clock (
        .clk (clk)
    );

    pipe_top #(
        .fifo_depth (depth)
    ) UUT (
        .clk              (clk),
        .reset            (reset),
        .flush_from_wb    (flush_from_wb),
        .flush_from_ex2   (flush_from_ex2),
        .flush_from_ex1   (flush_from_ex1),
        .flush_from_reg   (flush_from_reg),
        .flush_from_id    (flush_from_id),
        .flush_from_fifo  (flush_from_fifo),
        .flush_from_if1   (flush_from_if1),
        .redirect_pc_wb   (redirect_pc_wb),
        .redirect_pc_ex2  (redirect_pc_ex2),
        .redirect_pc_ex1  (redirect_pc_ex1),
        .redirect_pc_reg  (redirect_pc_reg),
        .redirect_pc_id   (redirect_pc_id),
        .redirect_pc_fifo (redirect_pc_fifo),
        .redirect_pc_if1  (redirect_pc_if1),
        .wb_valid         (wb_valid),
        .wb_pc            (wb_pc),
        .flush_to_tlb     (flush_to_tlb),
        .flush_to_icache  (flush_to_icache),
        .flush_to_dcache  (flush_to_dcache),
        .flush_to_btb     (flush_to_btb)
    );

    task automatic set_row(input int idx, input logic [n_flush_src-1:0] src,
                           input logic [addr_w-1:0] base, input logic [addr_w-1:0] win,
                           input logic [3:0] levels);
        row_src[idx]    = src;
        row_base[idx]   = base;
        row_win[idx]    = win;
        row_levels[idx] = levels;
    endtask

    // each source gets its own target, spaced 0x40 apart from the base.
    task automatic drive_sources(input logic [n_flush_src-1:0] src,
                                 input logic [addr_w-1:0] base);
        flush_from_wb    = src[src_wb];
        flush_from_ex2   = src[src_ex2];
        flush_from_ex1   = src[src_ex1];
        flush_from_reg   = src[src_reg];
        flush_from_id    = src[src_id];
        flush_from_fifo  = src[src_fifo];
        flush_from_if1   = src[src_if1];
        redirect_pc_wb   = base;
        redirect_pc_ex2  = base + 32'h040;
        redirect_pc_ex1  = base + 32'h080;
        redirect_pc_reg  = base + 32'h0c0;
        redirect_pc_id   = base + 32'h100;
        redirect_pc_fifo = base + 32'h140;
        redirect_pc_if1  = base + 32'h180;
    endtask

    task automatic apply_row(input int idx);
        logic [3:0] got;
        @(negedge clk);
        drive_sources(row_src[idx], row_base[idx]);
        @(posedge clk);
        got = {flush_to_tlb, flush_to_icache, flush_to_dcache, flush_to_btb};
        if (got !== row_levels[idx]) begin
            errors = errors + 1;
            $display("Error at %0t: row %0d flush levels %b, expected %b",
                     $time, idx, got, row_levels[idx]);
        end
        if (row_src[idx] != '0) begin
            pending_valid = 1'b1;
            pending_pc    = row_win[idx];
            pending_age   = 0;
        end
        @(negedge clk);
        if (row_src[idx][src_wb] && wb_valid) begin
            errors = errors + 1;
            $display("Error at %0t: row %0d retired %h right after a wb flush",
                     $time, idx, wb_pc);
        end
        drive_sources('0, row_base[idx]);
    endtask

    // retire stream checker.
    always @(negedge clk) begin
        if (reset) begin
            have_prev     = 1'b0;
            pending_valid = 1'b0;
        end else begin
            if (wb_valid) begin
                retires = retires + 1;
                if (!have_prev) begin
                    if (wb_pc !== reset_pc) begin
                        errors = errors + 1;
                        $display("Error at %0t: first retire %h, expected %h",
                                 $time, wb_pc, reset_pc);
                    end
                end else if (wb_pc === prev_pc) begin
                    errors = errors + 1;
                    $display("Error at %0t: pc %h retired twice in a row", $time, wb_pc);
                end else if (pending_valid && wb_pc === pending_pc) begin
                    pending_valid = 1'b0;
                end else if (wb_pc !== prev_pc + pc_step) begin
                    errors = errors + 1;
                    $display("Error at %0t: retired %h, expected %h or target %h",
                             $time, wb_pc, prev_pc + pc_step, pending_pc);
                end
                have_prev = 1'b1;
                prev_pc   = wb_pc;
            end
            if (pending_valid) begin
                pending_age = pending_age + 1;
                if (pending_age > depth + 8) begin
                    errors        = errors + 1;
                    pending_valid = 1'b0;
                    $display("Redirect target %h never retired in time", pending_pc);
                end
            end
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hd6c6));
        errors        = 0;
        retires       = 0;
        pending_age   = 0;
        have_prev     = 1'b0;
        pending_valid = 1'b0;
        prev_pc       = '0;
        pending_pc    = '0;
        reset         = 1'b1;
        drive_sources('0, '0);

        // winner is the target of the lowest set bit.
        set_row(0,  7'b0000000, 32'h0000_0000, 32'h0000_0000, 4'b0000);
        set_row(1,  7'b0000001, 32'h0000_2000, 32'h0000_2000, 4'b1111);
        set_row(2,  7'b0000010, 32'h0000_3000, 32'h0000_3040, 4'b1111);
        set_row(3,  7'b0000100, 32'h0000_4000, 32'h0000_4080, 4'b1111);
        set_row(4,  7'b0001000, 32'h0000_5000, 32'h0000_50c0, 4'b0101);
        set_row(5,  7'b0010000, 32'h0000_6000, 32'h0000_6100, 4'b0101);
        set_row(6,  7'b0100000, 32'h0000_7000, 32'h0000_7140, 4'b0101);
        set_row(7,  7'b1000000, 32'h0000_8000, 32'h0000_8180, 4'b0101);
        set_row(8,  7'b1111111, 32'h0000_9000, 32'h0000_9000, 4'b1111);
        set_row(9,  7'b1101000, 32'h0000_a000, 32'h0000_a0c0, 4'b0101);
        set_row(10, 7'b0010100, 32'h0000_b000, 32'h0000_b080, 4'b1111);
        set_row(11, 7'b1000010, 32'h0000_c000, 32'h0000_c040, 4'b1111);
        set_row(12, 7'b0110000, 32'h0000_d000, 32'h0000_d100, 4'b0101);

        repeat (4) @(negedge clk);
        reset = 1'b0;

        for (int r = 0; r < n_rows; r++) begin
            gap = min_gap + int'($urandom % (max_gap - min_gap + 1));
            repeat (gap) @(negedge clk);
            apply_row(r);
        end
        repeat (drain_cycles) @(negedge clk);

        if (pending_valid) begin
            errors = errors + 1;
            $display("Last redirect target %h did not retire", pending_pc);
        end
        if (retires == 0) begin
            errors = errors + 1;
            $display("No instruction retired during the run");
        end

        $display("%0d errors over %0d retires and %0d table rows", errors, retires, n_rows);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // free running, first rising edge at half a period.
    always #(period / 2) clk = ~clk;

endmodule

// ==== logic/pipe_top.sv ====
module pipe_top #(
    parameter int unsigned fifo_depth = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush_from_wb,
    input  logic                        flush_from_ex2,
    input  logic                        flush_from_ex1,
    input  logic                        flush_from_reg,
    input  logic                        flush_from_id,
    input  logic                        flush_from_fifo,
    input  logic                        flush_from_if1,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_wb,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_ex2,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_ex1,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_reg,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_id,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_fifo,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_if1,

    output logic                        wb_valid,
    output logic [pipe_pkg::addr_w-1:0] wb_pc,
    output logic                        flush_to_tlb,
    output logic                        flush_to_icache,
    output logic                        flush_to_dcache,
    output logic                        flush_to_btb
);
    import pipe_pkg::*;

    logic              flush_to_ex2_wb;
    logic              flush_to_ex1_ex2;
    logic              flush_to_reg_ex1;
    logic              flush_to_id_reg;
    logic              flush_to_fifo_id;
    logic              flush_to_if1_fifo;
    logic              flush_to_if0_if1;
    logic              redirect_valid;
    logic [addr_w-1:0] redirect_pc;
    logic              fifo_full;
    logic              if1_valid;
    logic [addr_w-1:0] if1_pc;
    logic              id_valid;
    logic [addr_w-1:0] id_pc;

    hazard_unit u_hazard (
        .flush_from_wb     (flush_from_wb),
        .flush_from_ex2    (flush_from_ex2),
        .flush_from_ex1    (flush_from_ex1),
        .flush_from_reg    (flush_from_reg),
        .flush_from_id     (flush_from_id),
        .flush_from_fifo   (flush_from_fifo),
        .flush_from_if1    (flush_from_if1),
        .redirect_pc_wb    (redirect_pc_wb),
        .redirect_pc_ex2   (redirect_pc_ex2),
        .redirect_pc_ex1   (redirect_pc_ex1),
        .redirect_pc_reg   (redirect_pc_reg),
        .redirect_pc_id    (redirect_pc_id),
        .redirect_pc_fifo  (redirect_pc_fifo),
        .redirect_pc_if1   (redirect_pc_if1),
        .flush_to_ex2_wb   (flush_to_ex2_wb),
        .flush_to_ex1_ex2  (flush_to_ex1_ex2),
        .flush_to_reg_ex1  (flush_to_reg_ex1),
        .flush_to_id_reg   (flush_to_id_reg),
        .flush_to_fifo_id  (flush_to_fifo_id),
        // queue contents die with its input boundary.
        .flush_to_fifo     (),
        .flush_to_if1_fifo (flush_to_if1_fifo),
        .flush_to_if0_if1  (flush_to_if0_if1),
        .flush_to_tlb      (flush_to_tlb),
        .flush_to_icache   (flush_to_icache),
        .flush_to_dcache   (flush_to_dcache),
        .flush_to_btb      (flush_to_btb),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc)
    );

    fetch_unit u_fetch (
        .clk              (clk),
        .reset            (reset),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .flush_to_if0_if1 (flush_to_if0_if1),
        .fifo_full        (fifo_full),
        .if1_valid        (if1_valid),
        .if1_pc           (if1_pc)
    );

    inst_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk        (clk),
        .reset      (reset),
        .push_valid (if1_valid),
        .push_pc    (if1_pc),
        .flush      (flush_to_if1_fifo),
        .full       (fifo_full),
        .id_valid   (id_valid),
        .id_pc      (id_pc)
    );

    backend_pipe u_backend (
        .clk              (clk),
        .reset            (reset),
        .id_valid         (id_valid),
        .id_pc            (id_pc),
        .flush_to_fifo_id (flush_to_fifo_id),
        .flush_to_id_reg  (flush_to_id_reg),
        .flush_to_reg_ex1 (flush_to_reg_ex1),
        .flush_to_ex1_ex2 (flush_to_ex1_ex2),
        .flush_to_ex2_wb  (flush_to_ex2_wb),
        .wb_valid         (wb_valid),
        .wb_pc            (wb_pc)
    );

endmodule

// ==== logic/backend_pipe.sv ====
module backend_pipe (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        id_valid,
    input  logic [pipe_pkg::addr_w-1:0] id_pc,
    input  logic                        flush_to_fifo_id,
    input  logic                        flush_to_id_reg,
    input  logic                        flush_to_reg_ex1,
    input  logic                        flush_to_ex1_ex2,
    input  logic                        flush_to_ex2_wb,

    output logic                        wb_valid,
    output logic [pipe_pkg::addr_w-1:0] wb_pc
);
    import pipe_pkg::*;

    // id, reg, ex1, ex2, wb.
    localparam int unsigned n_stage = 5;

    logic [n_stage-1:0] kill;
    logic [n_stage-1:0] valid_q;
    logic [addr_w-1:0]  pc_q [n_stage];

    // kill[i] guards the boundary feeding stage i.
    assign kill = {
        flush_to_ex2_wb,
        flush_to_ex1_ex2,
        flush_to_reg_ex1,
        flush_to_id_reg,
        flush_to_fifo_id
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= id_valid && !kill[0];
            for (int i = 1; i < n_stage; i++) begin
                valid_q[i] <= valid_q[i-1] && !kill[i];
            end
        end
    end

    // pc shifts unconditionally.
    always_ff @(posedge clk) begin
        pc_q[0] <= id_pc;
        for (int i = 1; i < n_stage; i++) begin
            pc_q[i] <= pc_q[i-1];
        end
    end

    assign wb_valid = valid_q[n_stage-1];
    assign wb_pc    = pc_q[n_stage-1];

    a_wb_killed: assert property (
        @(posedge clk) disable iff (reset)
        flush_to_ex2_wb |=> !wb_valid
    ) else $error("wb retired across a flushed boundary");

endmodule

// ==== logic/inst_fifo.sv ====
module inst_fifo #(
    parameter int unsigned fifo_depth = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        push_valid,
    input  logic [pipe_pkg::addr_w-1:0] push_pc,
    input  logic                        flush,

    output logic                        full,
    output logic                        id_valid,
    output logic [pipe_pkg::addr_w-1:0] id_pc
);
    import pipe_pkg::*;

    localparam int unsigned ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int unsigned cnt_w = $clog2(fifo_depth + 1);

    logic [addr_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              push;
    logic              pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == cnt_w'(fifo_depth));
    assign push     = push_valid && !full;
    // id never stalls, so the head leaves every cycle.
    assign pop      = (count != '0);

    assign id_valid = pop;
    assign id_pc    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage.
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pc;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        count <= cnt_w'(fifo_depth)
    ) else $error("queue count above depth");

    // full blocks the push but the head still drains.
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset)
        full && !flush |=> count < cnt_w'(fifo_depth)
    ) else $error("queue took a push while full");

endmodule

// ==== logic/fetch_unit.sv ====
module fetch_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        redirect_valid,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc,
    input  logic                        flush_to_if0_if1,
    input  logic                        fifo_full,

    output logic                        if1_valid,
    output logic [pipe_pkg::addr_w-1:0] if1_pc
);
    import pipe_pkg::*;

    logic [addr_w-1:0] if0_pc;

    // if0 pc register.
    always_ff @(posedge clk) begin
        if (reset) begin
            if0_pc <= reset_pc;
        end else if (redirect_valid) begin
            if0_pc <= redirect_pc;
        end else if (!fifo_full) begin
            if0_pc <= if0_pc + pc_step;
        end
    end

    // if1 valid, killed by any flush.
    always_ff @(posedge clk) begin
        if (reset) begin
            if1_valid <= 1'b0;
        end else if (flush_to_if0_if1) begin
            if1_valid <= 1'b0;
        end else if (!fifo_full) begin
            if1_valid <= 1'b1;
        end
    end

    // if1 holds its pc while the queue is full.
    always_ff @(posedge clk) begin
        if (!fifo_full) begin
            if1_pc <= if0_pc;
        end
    end

    // a full queue freezes if0 unless the flow is redirected.
    a_hold_on_full: assert property (
        @(posedge clk) disable iff (reset)
        fifo_full && !redirect_valid |=> $stable(if0_pc)
    ) else $error("if0 pc moved while queue full");

endmodule

// ==== logic/hazard_unit.sv ====
module hazard_unit (
    input  logic                        flush_from_wb,
    input  logic                        flush_from_ex2,
    input  logic                        flush_from_ex1,
    input  logic                        flush_from_reg,
    input  logic                        flush_from_id,
    input  logic                        flush_from_fifo,
    input  logic                        flush_from_if1,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_wb,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_ex2,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_ex1,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_reg,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_id,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_fifo,
    input  logic [pipe_pkg::addr_w-1:0] redirect_pc_if1,

    output logic                        flush_to_ex2_wb,
    output logic                        flush_to_ex1_ex2,
    output logic                        flush_to_reg_ex1,
    output logic                        flush_to_id_reg,
    output logic                        flush_to_fifo_id,
    output logic                        flush_to_fifo,
    output logic                        flush_to_if1_fifo,
    output logic                        flush_to_if0_if1,
    output logic                        flush_to_tlb,
    output logic                        flush_to_icache,
    output logic                        flush_to_dcache,
    output logic                        flush_to_btb,
    output logic                        redirect_valid,
    output logic [pipe_pkg::addr_w-1:0] redirect_pc
);
    import pipe_pkg::*;

    logic [n_flush_src-1:0] src;
    logic [n_flush_src-1:0] hit;
    logic [n_flush_src-1:0] grant;
    logic [addr_w-1:0]      target [n_flush_src];

    assign src[src_wb]   = flush_from_wb;
    assign src[src_ex2]  = flush_from_ex2;
    assign src[src_ex1]  = flush_from_ex1;
    assign src[src_reg]  = flush_from_reg;
    assign src[src_id]   = flush_from_id;
    assign src[src_fifo] = flush_from_fifo;
    assign src[src_if1]  = flush_from_if1;

    assign target[src_wb]   = redirect_pc_wb;
    assign target[src_ex2]  = redirect_pc_ex2;
    assign target[src_ex1]  = redirect_pc_ex1;
    assign target[src_reg]  = redirect_pc_reg;
    assign target[src_id]   = redirect_pc_id;
    assign target[src_fifo] = redirect_pc_fifo;
    assign target[src_if1]  = redirect_pc_if1;

    // hit[i] is set when stage i or anything older asks for a flush.
    always_comb begin
        logic acc;
        acc = 1'b0;
        for (int i = 0; i < n_flush_src; i++) begin
            acc    = acc | src[i];
            hit[i] = acc;
        end
    end

    // oldest requester wins the redirect.
    assign grant = src & ~{hit[n_flush_src-2:0], 1'b0};

    always_comb begin
        redirect_pc = '0;
        for (int i = 0; i < n_flush_src; i++) begin
            if (grant[i]) begin
                redirect_pc = redirect_pc | target[i];
            end
        end
    end

    assign redirect_valid    = hit[src_if1];

    assign flush_to_ex2_wb   = hit[src_wb];
    assign flush_to_ex1_ex2  = hit[src_ex2];
    assign flush_to_reg_ex1  = hit[src_ex1];
    assign flush_to_id_reg   = hit[src_reg];
    assign flush_to_fifo_id  = hit[src_id];
    assign flush_to_fifo     = hit[src_fifo];
    assign flush_to_if1_fifo = hit[src_fifo];
    assign flush_to_if0_if1  = hit[src_if1];

    // memory side only sees flushes from ex1 and older.
    assign flush_to_tlb      = flush_to_reg_ex1;
    assign flush_to_dcache   = flush_to_reg_ex1;
    assign flush_to_icache   = flush_to_if0_if1;
    assign flush_to_btb      = flush_to_if0_if1;

    // a killed boundary implies every younger one dies too.
    always_comb begin
        assert ((!flush_to_ex2_wb   || flush_to_ex1_ex2)  &&
                (!flush_to_ex1_ex2  || flush_to_reg_ex1)  &&
                (!flush_to_reg_ex1  || flush_to_id_reg)   &&
                (!flush_to_id_reg   || flush_to_fifo_id)  &&
                (!flush_to_fifo_id  || flush_to_fifo)     &&
                (!flush_to_fifo     || flush_to_if1_fifo) &&
                (!flush_to_if1_fifo || flush_to_if0_if1)  &&
                (!flush_to_tlb      || flush_to_icache))
        else $error("flush fan-out not monotonic");
    end

endmodule

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

    // pc width.
    localparam int unsigned addr_w = 32;

    // first fetch after reset.
    localparam logic [addr_w-1:0] reset_pc = 32'h0000_1000;

    // sequential fetch increment.
    localparam logic [addr_w-1:0] pc_step = 32'd4;

    // flush sources, oldest first.
    localparam int unsigned n_flush_src = 7;

    localparam int unsigned src_wb   = 0;
    localparam int unsigned src_ex2  = 1;
    localparam int unsigned src_ex1  = 2;
    localparam int unsigned src_reg  = 3;
    localparam int unsigned src_id   = 4;
    localparam int unsigned src_fifo = 5;
    localparam int unsigned src_if1  = 6;

endpackage
